// ==== include/led_display_config.svh ====
`ifndef LED_DISPLAY_CONFIG_SVH
`define LED_DISPLAY_CONFIG_SVH

// parallel serial data lanes into the driver chain
`define LED_LANES 30

// shift clocks per grayscale frame
`define LED_GS_BITS 48

// shift clocks per configuration frame
`define LED_CONF_BITS 48

// columns on the board
`define LED_COLUMNS 8

// system clocks per enable strobe
`define LED_CLK_DIV 4

// enable ticks of blanking after each latch
`define LED_BLANK_TICKS 72

`endif

// ==== design/led_display_pkg.sv ====
`default_nettype none

`include "led_display_config.svh"

package led_display_pkg;

    // one bit per serial lane
    typedef logic [`LED_LANES-1:0] lane_data_t;

    // driver configuration word
    typedef logic [`LED_CONF_BITS-1:0] conf_word_t;

    // shift position inside a frame
    typedef logic [5:0] bit_index_t;

    // one-hot column select
    typedef logic [`LED_COLUMNS-1:0] column_sel_t;

    // register interface
    typedef logic [1:0] reg_addr_t;
    typedef logic [15:0] reg_data_t;

    // controller sequence
    typedef enum logic [2:0] {
        IDLE,
        CONF_LOW,
        CONF_HIGH,
        GS_LOW,
        GS_HIGH,
        LATCH,
        BLANK
    } ctrl_state_t;

    // register block view handed to the controller
    typedef struct packed {
        conf_word_t conf;
        logic conf_pending;
        logic driver_enable;
        logic mux_enable;
    } display_cfg_t;

endpackage

`default_nettype wire

// ==== design/clock_enable.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_display_config.svh"

module clock_enable (
    input  wire  clk,
    input  wire  nrst,
    output logic tick
);

    localparam int unsigned DIV_W = $clog2(`LED_CLK_DIV);

    logic [DIV_W-1:0] div_cnt;

    // free running divider, tick on the wrap
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            div_cnt <= '0;
            tick <= 1'b0;
        end else begin
            if (div_cnt == DIV_W'(`LED_CLK_DIV - 1)) begin
                div_cnt <= '0;
            end else begin
                div_cnt <= div_cnt + 1'b1;
            end
            tick <= (div_cnt == DIV_W'(`LED_CLK_DIV - 1));
        end
    end

    // everything downstream assumes ticks are separated
    a_tick_single : assert property (@(posedge clk) disable iff (!nrst) tick |=> !tick)
        else $error("clock_enable: tick high on consecutive cycles");

endmodule

`default_nettype wire

// ==== design/driver_config_regs.sv ====
`timescale 1ns/1ps
`default_nettype none

module driver_config_regs (
    input  wire                         clk,
    input  wire                         nrst,
    input  wire                         cfg_write,
    input  led_display_pkg::reg_addr_t  cfg_addr,
    input  led_display_pkg::reg_data_t  cfg_wdata,
    input  wire                         conf_taken,
    output led_display_pkg::display_cfg_t display_cfg
);

    // conf word split over three registers, high part at address 0
    led_display_pkg::reg_data_t conf_high;
    led_display_pkg::reg_data_t conf_mid;
    led_display_pkg::reg_data_t conf_low;

    logic conf_pending;
    logic driver_enable;
    logic mux_enable;

    always_ff @(posedge clk) begin
        if (cfg_write) begin
            case (cfg_addr)
                2'd0: conf_high <= cfg_wdata;
                2'd1: conf_mid <= cfg_wdata;
                2'd2: conf_low <= cfg_wdata;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            driver_enable <= 1'b0;
            mux_enable <= 1'b0;
        end else if (cfg_write && cfg_addr == 2'd3) begin
            driver_enable <= cfg_wdata[0];
            mux_enable <= cfg_wdata[1];
        end
    end

    // a write to the low word arms a new config frame
    // and wins over a clear in the same cycle
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            conf_pending <= 1'b0;
        end else if (cfg_write && cfg_addr == 2'd2) begin
            conf_pending <= 1'b1;
        end else if (conf_taken) begin
            conf_pending <= 1'b0;
        end
    end

    always_comb begin
        display_cfg.conf = {conf_high, conf_mid, conf_low};
        display_cfg.conf_pending = conf_pending;
        display_cfg.driver_enable = driver_enable;
        display_cfg.mux_enable = mux_enable;
    end

endmodule

`default_nettype wire

// ==== design/driver_controller.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_display_config.svh"

module driver_controller (
    input  wire                           clk,
    input  wire                           nrst,
    input  wire                           tick,
    input  led_display_pkg::display_cfg_t display_cfg,
    input  led_display_pkg::lane_data_t   framebuffer_data,
    output led_display_pkg::bit_index_t   bit_index,
    output led_display_pkg::lane_data_t   drivers_sin,
    output logic                          sclk,
    output logic                          lat,
    output logic                          gclk,
    output logic                          driver_ready,
    output logic                          conf_taken,
    output logic                          column_done
);

    localparam int unsigned BLANK_W = $clog2(`LED_BLANK_TICKS);

    led_display_pkg::ctrl_state_t state;
    led_display_pkg::bit_index_t bit_cnt;
    led_display_pkg::conf_word_t conf_shift;
    logic conf_frame;
    logic [BLANK_W-1:0] blank_cnt;

    assign bit_index = bit_cnt;
    assign driver_ready = (state == led_display_pkg::IDLE);

    // config word is captured at frame start, then sent MSB first
    always_ff @(posedge clk) begin
        if (tick) begin
            if (state == led_display_pkg::IDLE) begin
                conf_shift <= display_cfg.conf;
            end else if (state == led_display_pkg::CONF_HIGH) begin
                conf_shift <= conf_shift << 1;
            end
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= led_display_pkg::IDLE;
            bit_cnt <= '0;
            conf_frame <= 1'b0;
            blank_cnt <= '0;
            sclk <= 1'b0;
            lat <= 1'b0;
            gclk <= 1'b0;
            drivers_sin <= '0;
            conf_taken <= 1'b0;
            column_done <= 1'b0;
        end else begin
            conf_taken <= 1'b0;
            column_done <= 1'b0;
            if (tick) begin
                // grayscale clock runs whenever the drivers are on
                if (display_cfg.driver_enable) begin
                    gclk <= ~gclk;
                end
                case (state)
                    led_display_pkg::IDLE: begin
                        if (display_cfg.driver_enable) begin
                            bit_cnt <= '0;
                            if (display_cfg.conf_pending) begin
                                conf_frame <= 1'b1;
                                conf_taken <= 1'b1;
                                state <= led_display_pkg::CONF_LOW;
                            end else begin
                                conf_frame <= 1'b0;
                                state <= led_display_pkg::GS_LOW;
                            end
                        end
                    end
                    // data changes while sclk falls
                    led_display_pkg::CONF_LOW: begin
                        sclk <= 1'b0;
                        drivers_sin <= {`LED_LANES{conf_shift[`LED_CONF_BITS-1]}};
                        state <= led_display_pkg::CONF_HIGH;
                    end
                    led_display_pkg::GS_LOW: begin
                        sclk <= 1'b0;
                        drivers_sin <= framebuffer_data;
                        state <= led_display_pkg::GS_HIGH;
                    end
                    // receiver samples on this rising edge
                    led_display_pkg::CONF_HIGH: begin
                        sclk <= 1'b1;
                        if (bit_cnt == 6'(`LED_CONF_BITS - 1)) begin
                            state <= led_display_pkg::LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state <= led_display_pkg::CONF_LOW;
                        end
                    end
                    led_display_pkg::GS_HIGH: begin
                        sclk <= 1'b1;
                        if (bit_cnt == 6'(`LED_GS_BITS - 1)) begin
                            state <= led_display_pkg::LATCH;
                        end else begin
                            bit_cnt <= bit_cnt + 1'b1;
                            state <= led_display_pkg::GS_LOW;
                        end
                    end
                    // lat rises as sclk drops, held for one tick period
                    led_display_pkg::LATCH: begin
                        if (!lat) begin
                            sclk <= 1'b0;
                            lat <= 1'b1;
                        end else begin
                            lat <= 1'b0;
                            bit_cnt <= '0;
                            blank_cnt <= '0;
                            if (conf_frame) begin
                                conf_frame <= 1'b0;
                                state <= led_display_pkg::GS_LOW;
                            end else begin
                                state <= led_display_pkg::BLANK;
                            end
                        end
                    end
                    led_display_pkg::BLANK: begin
                        if (blank_cnt == BLANK_W'(`LED_BLANK_TICKS - 1)) begin
                            column_done <= 1'b1;
                            state <= led_display_pkg::IDLE;
                        end else begin
                            blank_cnt <= blank_cnt + 1'b1;
                        end
                    end
                    default: state <= led_display_pkg::IDLE;
                endcase
            end
        end
    end

    a_sclk_lat_excl : assert property (@(posedge clk) disable iff (!nrst) !(sclk && lat))
        else $error("driver_controller: sclk and lat high together");

    // lat spans exactly one tick period
    a_lat_width : assert property (@(posedge clk) disable iff (!nrst)
        $rose(lat) |-> lat [*`LED_CLK_DIV] ##1 !lat)
        else $error("driver_controller: lat width is not one tick period");

    a_done_pulse : assert property (@(posedge clk) disable iff (!nrst)
        column_done |=> !column_done)
        else $error("driver_controller: column_done longer than one cycle");

endmodule

`default_nettype wire

// ==== design/column_mux.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_display_config.svh"

module column_mux (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire                          column_done,
    input  wire                          mux_enable,
    output led_display_pkg::column_sel_t mux_out
);

    led_display_pkg::column_sel_t column_sel;

    // rotate left, top column wraps to column 0
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            column_sel <= led_display_pkg::column_sel_t'(1);
        end else if (column_done) begin
            column_sel <= {column_sel[`LED_COLUMNS-2:0], column_sel[`LED_COLUMNS-1]};
        end
    end

    // rows stay dark while disabled, rotation keeps going
    assign mux_out = mux_enable ? column_sel : '0;

    a_sel_onehot : assert property (@(posedge clk) disable iff (!nrst) $onehot(column_sel))
        else $error("column_mux: column select not one-hot");

endmodule

`default_nettype wire

// ==== design/led_display_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module led_display_top (
    input  wire                          clk,
    input  wire                          nrst,
    input  wire                          cfg_write,
    input  led_display_pkg::reg_addr_t   cfg_addr,
    input  led_display_pkg::reg_data_t   cfg_wdata,
    input  led_display_pkg::lane_data_t  framebuffer_data,
    output led_display_pkg::bit_index_t  bit_index,
    output led_display_pkg::lane_data_t  drivers_sin,
    output logic                         sclk,
    output logic                         lat,
    output logic                         gclk,
    output logic                         driver_ready,
    output logic                         column_done,
    output led_display_pkg::column_sel_t mux_out
);

    logic tick;
    logic conf_taken;
    led_display_pkg::display_cfg_t display_cfg;

    clock_enable u_clock_enable (
        .clk  (clk),
        .nrst (nrst),
        .tick (tick)
    );

    driver_config_regs u_driver_config_regs (
        .clk         (clk),
        .nrst        (nrst),
        .cfg_write   (cfg_write),
        .cfg_addr    (cfg_addr),
        .cfg_wdata   (cfg_wdata),
        .conf_taken  (conf_taken),
        .display_cfg (display_cfg)
    );

    driver_controller u_driver_controller (
        .clk              (clk),
        .nrst             (nrst),
        .tick             (tick),
        .display_cfg      (display_cfg),
        .framebuffer_data (framebuffer_data),
        .bit_index        (bit_index),
        .drivers_sin      (drivers_sin),
        .sclk             (sclk),
        .lat              (lat),
        .gclk             (gclk),
        .driver_ready     (driver_ready),
        .conf_taken       (conf_taken),
        .column_done      (column_done)
    );

    // column select follows the end of each blanking period
    column_mux u_column_mux (
        .clk         (clk),
        .nrst        (nrst),
        .column_done (column_done),
        .mux_enable  (display_cfg.mux_enable),
        .mux_out     (mux_out)
    );

endmodule

`default_nettype wire

// ==== verif/tb_led_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "led_display_config.svh"

module tb_led_display;

    typedef enum logic [1:0] {REG_WRITE, WAIT_COLUMN, WAIT_CYCLES} entry_kind_t;

    typedef struct packed {
        entry_kind_t kind;
        led_display_pkg::reg_addr_t addr;
        led_display_pkg::reg_data_t data;
        led_display_pkg::column_sel_t exp_sel;
    } stim_entry_t;

    // worst case column with a config frame plus some slack
    localparam int COLUMN_CYCLES =
        (2 * `LED_CONF_BITS + 2 * `LED_GS_BITS + `LED_BLANK_TICKS + 8) * `LED_CLK_DIV;

    logic clk;
    logic nrst;
    logic cfg_write;
    led_display_pkg::reg_addr_t cfg_addr;
    led_display_pkg::reg_data_t cfg_wdata;
    led_display_pkg::lane_data_t framebuffer_data;
    led_display_pkg::bit_index_t bit_index;
    led_display_pkg::lane_data_t drivers_sin;
    logic sclk;
    logic lat;
    logic gclk;
    logic driver_ready;
    logic column_done;
    led_display_pkg::column_sel_t mux_out;

    stim_entry_t stim_q[$];
    led_display_pkg::lane_data_t cap_q[$];
    int lat_pos[$];
    int sclk_rises;
    int gclk_edges;
    int gclk_gap;
    int mismatches;
    int failures;
    int cycle_count;
    int timeout_limit;
    int model_col;
    logic sclk_q;
    logic lat_q;
    logic gclk_q;
    logic model_pending;
    logic model_drv_en;
    led_display_pkg::reg_data_t model_conf [0:2];

    led_display_top u_led_display_top (
        .clk              (clk),
        .nrst             (nrst),
        .cfg_write        (cfg_write),
        .cfg_addr         (cfg_addr),
        .cfg_wdata        (cfg_wdata),
        .framebuffer_data (framebuffer_data),
        .bit_index        (bit_index),
        .drivers_sin      (drivers_sin),
        .sclk             (sclk),
        .lat              (lat),
        .gclk             (gclk),
        .driver_ready     (driver_ready),
        .column_done      (column_done),
        .mux_out          (mux_out)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] state);
        return state * 32'd1103515245 + 32'd12345;
    endfunction

    // pixel data depends on seed, column and shift position
    function automatic led_display_pkg::lane_data_t fb_value(input int col,
                                                             input led_display_pkg::bit_index_t idx);
        logic [31:0] x;
        x = lcg_next(32'd49 ^ (32'(col) << 16) ^ (32'(idx) << 8));
        x = lcg_next(x);
        return x[31 -: `LED_LANES];
    endfunction

    // framebuffer model
    assign framebuffer_data = fb_value(model_col, bit_index);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // capture data on each sclk rise and note where each latch lands
    always @(posedge clk) begin
        sclk_q <= sclk;
        lat_q <= lat;
        gclk_q <= gclk;
        if (nrst) begin
            if (sclk && !sclk_q) begin
                cap_q.push_back(drivers_sin);
                sclk_rises++;
            end
            if (lat && !lat_q) begin
                lat_pos.push_back(cap_q.size());
            end
            // gclk toggles once per tick while the drivers run
            if (gclk != gclk_q) begin
                gclk_edges++;
                if (model_drv_en && gclk_gap > 0) begin
                    check_value("gclk edge spacing", 64'(gclk_gap), 64'(`LED_CLK_DIV));
                end
                gclk_gap = 1;
            end else if (gclk_gap > 0) begin
                gclk_gap++;
            end
            if (!model_drv_en) begin
                gclk_gap = 0;
            end else if (gclk_gap > `LED_CLK_DIV) begin
                failures++;
                $display("gclk stopped toggling at %0t", $time);
                gclk_gap = 0;
            end
        end
    end

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("Timeout: run did not finish within %0d cycles", timeout_limit);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    task automatic check_value(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            mismatches++;
            $display("Mismatch at %0t: %s got %0h expected %0h", $time, name, got, exp);
        end
    endtask

    task automatic add_entry(input entry_kind_t kind, input logic [1:0] addr,
                             input logic [15:0] data, input logic [7:0] exp_sel);
        stim_entry_t e;
        e.kind = kind;
        e.addr = addr;
        e.data = data;
        e.exp_sel = exp_sel;
        stim_q.push_back(e);
    endtask

    task automatic check_quiet_outputs();
        check_value("sclk", 64'(sclk), 64'd0);
        check_value("lat", 64'(lat), 64'd0);
        check_value("gclk", 64'(gclk), 64'd0);
        check_value("drivers_sin", 64'(drivers_sin), 64'd0);
        check_value("mux_out", 64'(mux_out), 64'd0);
        check_value("driver_ready", 64'(driver_ready), 64'd1);
        check_value("column_done", 64'(column_done), 64'd0);
    endtask

    task automatic write_register(input led_display_pkg::reg_addr_t addr,
                                  input led_display_pkg::reg_data_t data);
        cfg_write <= 1'b1;
        cfg_addr <= addr;
        cfg_wdata <= data;
        @(posedge clk);
        cfg_write <= 1'b0;
        if (addr == 2'd3) begin
            model_drv_en = data[0];
        end else begin
            model_conf[addr] = data;
        end
        if (addr == 2'd2) begin
            model_pending = 1'b1;
        end
    endtask

    // with the drivers off nothing may move on sclk or gclk
    task automatic idle_cycles(input int n);
        int sclk_start;
        int gclk_start;
        sclk_start = sclk_rises;
        gclk_start = gclk_edges;
        repeat (n) begin
            @(posedge clk);
            if (!model_drv_en) begin
                check_value("driver_ready", 64'(driver_ready), 64'd1);
            end
        end
        if (!model_drv_en) begin
            check_value("sclk rises while idle", 64'(sclk_rises - sclk_start), 64'd0);
            check_value("gclk edges while idle", 64'(gclk_edges - gclk_start), 64'd0);
        end
    endtask

    task automatic run_column();
        logic expect_conf;
        led_display_pkg::conf_word_t conf;
        int exp_len;
        int base;
        int gclk_start;
        expect_conf = model_pending;
        conf = {model_conf[0], model_conf[1], model_conf[2]};
        exp_len = expect_conf ? `LED_CONF_BITS + `LED_GS_BITS : `LED_GS_BITS;
        gclk_start = gclk_edges;
        @(posedge clk);
        while (!column_done) begin
            @(posedge clk);
        end
        if (gclk_edges == gclk_start) begin
            failures++;
            $display("gclk did not toggle during column %0d", model_col);
        end
        check_value("lat pulses", 64'(lat_pos.size()), expect_conf ? 64'd2 : 64'd1);
        if (lat_pos.size() > 0) begin
            check_value("first lat position", 64'(lat_pos[0]),
                        expect_conf ? 64'(`LED_CONF_BITS) : 64'(`LED_GS_BITS));
        end
        if (expect_conf && lat_pos.size() > 1) begin
            check_value("second lat position", 64'(lat_pos[1]), 64'(exp_len));
        end
        if (cap_q.size() != exp_len) begin
            failures++;
            $display("Column %0d shifted %0d bits instead of %0d", model_col, cap_q.size(), exp_len);
        end else begin
            base = 0;
            if (expect_conf) begin
                for (int k = 0; k < `LED_CONF_BITS; k++) begin
                    check_value("drivers_sin conf bit", 64'(cap_q[k]),
                                64'({`LED_LANES{conf[`LED_CONF_BITS-1-k]}}));
                end
                base = `LED_CONF_BITS;
            end
            for (int k = 0; k < `LED_GS_BITS; k++) begin
                check_value("drivers_sin gs bit", 64'(cap_q[base+k]),
                            64'(fb_value(model_col, led_display_pkg::bit_index_t'(k))));
            end
        end
        cap_q.delete();
        lat_pos.delete();
        if (expect_conf) begin
            model_pending = 1'b0;
        end
        model_col = (model_col + 1) % `LED_COLUMNS;
    endtask

    initial begin
        nrst = 1'b0;
        cfg_write = 1'b0;
        cfg_addr = '0;
        cfg_wdata = '0;
        sclk_rises = 0;
        gclk_edges = 0;
        gclk_gap = 0;
        mismatches = 0;
        failures = 0;
        cycle_count = 0;
        model_col = 0;
        model_pending = 1'b0;
        model_drv_en = 1'b0;
        model_conf[0] = '0;
        model_conf[1] = '0;
        model_conf[2] = '0;

        // config words go in while the drivers stay off
        add_entry(REG_WRITE, 2'd0, 16'hA5C3, 8'h00);
        add_entry(REG_WRITE, 2'd1, 16'h0FF0, 8'h00);
        add_entry(REG_WRITE, 2'd2, 16'h9617, 8'h00);
        add_entry(WAIT_CYCLES, 2'd0, 16'd20, 8'h00);
        add_entry(REG_WRITE, 2'd3, 16'h0003, 8'h01);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h02);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h04);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h08);
        // mux off while the rotation keeps going underneath
        add_entry(REG_WRITE, 2'd3, 16'h0001, 8'h00);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h00);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h00);
        add_entry(REG_WRITE, 2'd3, 16'h0003, 8'h20);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h40);
        // drivers off for a new config word and back on
        add_entry(REG_WRITE, 2'd3, 16'h0002, 8'h40);
        add_entry(WAIT_CYCLES, 2'd0, 16'd40, 8'h40);
        add_entry(REG_WRITE, 2'd2, 16'h1234, 8'h40);
        add_entry(REG_WRITE, 2'd0, 16'hFACE, 8'h40);
        add_entry(REG_WRITE, 2'd3, 16'h0003, 8'h40);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h80);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h01);
        add_entry(WAIT_COLUMN, 2'd0, 16'h0000, 8'h02);
        timeout_limit = (stim_q.size() + 1) * COLUMN_CYCLES;

        repeat (5) @(posedge clk);
        check_quiet_outputs();
        repeat (5) @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);
        check_quiet_outputs();

        foreach (stim_q[i]) begin
            case (stim_q[i].kind)
                REG_WRITE: write_register(stim_q[i].addr, stim_q[i].data);
                WAIT_COLUMN: run_column();
                default: idle_cycles(int'(stim_q[i].data));
            endcase
            @(posedge clk);
            check_value("mux_out", 64'(mux_out), 64'(stim_q[i].exp_sel));
        end

        $display("Errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+include
design/led_display_pkg.sv
design/clock_enable.sv
design/driver_config_regs.sv
design/driver_controller.sv
design/column_mux.sv
design/led_display_top.sv
verif/tb_led_display.sv

// ==== Makefile ====
# Verilator build and run for the LED display controller

VERILATOR  ?= verilator
TOP        ?= tb_led_display
FILELIST   ?= src.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation finished: FAIL" $(LOG); then \
		echo "simulation reported failure"; exit 1; fi
	@grep -q "Simulation finished: PASS" $(LOG) || \
		(echo "no pass result found in $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
